/* Bender.yml */
package:
  name: axi_dc_read_master

sources:
  - files:
      - design/axi_dc_pkg.sv
      - design/dc_token_ring_reader.sv
      - design/dc_token_ring_writer.sv
      - design/req_buffer_fifo.sv
      - design/axi_dc_read_master.sv
  - target: test
    files:
      - bench/tb_clk_gen.sv
      - bench/tb_axi_dc_read_master.sv

/* bench/tb_axi_dc_read_master.sv */
// Both ring sides share the testbench clock; far AR writer and far R reader are models
// Default DUT parameters only, 300 AR requests and 300 R beats from a fixed seed
`timescale 1ns/1ns

module tb_axi_dc_read_master
    import axi_dc_pkg::*;
();

    localparam int BUFFER_WIDTH = DEF_BUFFER_WIDTH;
    localparam int AR_W         = AR_CTRL_W + DEF_ADDR_W + DEF_ID_W + DEF_USER_W;
    localparam int R_W          = R_DATA_LSB + DEF_DATA_W + DEF_ID_W + DEF_USER_W;
    localparam int AR_ADDR_LSB  = AR_CTRL_W;
    localparam int AR_ID_LSB    = AR_ADDR_LSB + DEF_ADDR_W;
    localparam int AR_USER_LSB  = AR_ID_LSB + DEF_ID_W;
    localparam int R_ID_LSB     = R_DATA_LSB + DEF_DATA_W;
    localparam int R_USER_LSB   = R_ID_LSB + DEF_ID_W;
    localparam int AR_BUS_W     = DEF_ADDR_W + PROT_W + REGION_W + LEN_W + SIZE_W + BURST_W
                                  + 1 + CACHE_W + QOS_W + DEF_ID_W + DEF_USER_W;
    localparam int NUM_AR       = 300;
    localparam int NUM_R        = 300;
    // About 600 transfers at a few cycles each, plus stall windows and a wide margin
    localparam int MAX_CYCLES   = 20000;

    logic clk;
    logic rst_n;

    logic [BUFFER_WIDTH-1:0] ar_writetoken_i;
    logic [AR_W-1:0]         ar_data_async_i;
    logic [BUFFER_WIDTH-1:0] ar_readpointer_o;
    logic                    ar_valid_o;
    logic [DEF_ADDR_W-1:0]   ar_addr_o;
    logic [PROT_W-1:0]       ar_prot_o;
    logic [REGION_W-1:0]     ar_region_o;
    logic [LEN_W-1:0]        ar_len_o;
    logic [SIZE_W-1:0]       ar_size_o;
    logic [BURST_W-1:0]      ar_burst_o;
    logic                    ar_lock_o;
    logic [CACHE_W-1:0]      ar_cache_o;
    logic [QOS_W-1:0]        ar_qos_o;
    logic [DEF_ID_W-1:0]     ar_id_o;
    logic [DEF_USER_W-1:0]   ar_user_o;
    logic                    ar_ready_i;
    logic                    r_valid_i;
    logic [DEF_DATA_W-1:0]   r_data_i;
    logic [RESP_W-1:0]       r_resp_i;
    logic                    r_last_i;
    logic [DEF_ID_W-1:0]     r_id_i;
    logic [DEF_USER_W-1:0]   r_user_i;
    logic                    r_ready_o;
    logic [BUFFER_WIDTH-1:0] r_readpointer_i;
    logic [BUFFER_WIDTH-1:0] r_writetoken_o;
    logic [R_W-1:0]          r_data_async_o;

    integer          seed;
    logic [AR_W-1:0] ar_slots [BUFFER_WIDTH];
    logic [AR_W-1:0] ar_pending [$];
    logic [AR_W-1:0] ar_ref_q [$];
    logic [R_W-1:0]  r_pending [$];
    logic [R_W-1:0]  r_ref_q [$];
    logic [R_W-1:0]  r_beat_cur;
    logic [AR_BUS_W-1:0] ar_bus;
    logic [AR_BUS_W-1:0] ar_bus_q;
    logic            ar_stalled_q;
    logic            saw_r_full;
    int              ar_issued;
    int              r_accepted;
    int              r_read;
    int              cycle_count;

    tb_clk_gen clk_gen (
        .clk_o   ( clk   ),
        .rst_n_o ( rst_n )
    );

    axi_dc_read_master axi_dc_read_master_inst (
        .clk_i   ( clk   ),
        .rst_n_i ( rst_n ),
        .*
    );

    assign ar_bus = {ar_addr_o, ar_prot_o, ar_region_o, ar_len_o, ar_size_o, ar_burst_o,
                     ar_lock_o, ar_cache_o, ar_qos_o, ar_id_o, ar_user_o};

    // Far AR ring shows the slot under the DUT read pointer
    always_comb begin
        ar_data_async_i = '0;
        for (int i = 0; i < BUFFER_WIDTH; i++) begin
            if (ar_readpointer_o[i]) begin
                ar_data_async_i = ar_slots[i];
            end
        end
    end

    function automatic logic [BUFFER_WIDTH-1:0] next_slot(input logic [BUFFER_WIDTH-1:0] tok);
        return {tok[BUFFER_WIDTH-2:0], tok[BUFFER_WIDTH-1]};
    endfunction

    function automatic logic [AR_W-1:0] random_ar_word();
        logic [AR_W-1:0] w;
        w = '0;
        w[AR_CACHE_LSB +: CACHE_W]   = CACHE_W'($random(seed));
        w[AR_PROT_LSB +: PROT_W]     = PROT_W'($random(seed));
        w[AR_LOCK_LSB]               = 1'($random(seed));
        w[AR_BURST_LSB +: BURST_W]   = BURST_W'($random(seed));
        w[AR_SIZE_LSB +: SIZE_W]     = SIZE_W'($random(seed));
        w[AR_LEN_LSB +: LEN_W]       = LEN_W'($random(seed));
        w[AR_REGION_LSB +: REGION_W] = REGION_W'($random(seed));
        w[AR_QOS_LSB +: QOS_W]       = QOS_W'($random(seed));
        w[AR_ADDR_LSB +: DEF_ADDR_W] = DEF_ADDR_W'($random(seed));
        w[AR_ID_LSB +: DEF_ID_W]     = DEF_ID_W'($random(seed));
        w[AR_USER_LSB +: DEF_USER_W] = DEF_USER_W'($random(seed));
        return w;
    endfunction

    function automatic logic [R_W-1:0] random_r_word();
        logic [R_W-1:0] w;
        w[R_LAST_LSB]                = 1'($random(seed));
        w[R_RESP_LSB +: RESP_W]      = RESP_W'($random(seed));
        w[R_DATA_LSB +: DEF_DATA_W]  = {$random(seed), $random(seed)};
        w[R_ID_LSB +: DEF_ID_W]      = DEF_ID_W'($random(seed));
        w[R_USER_LSB +: DEF_USER_W]  = DEF_USER_W'($random(seed));
        return w;
    endfunction

    task automatic fail_run(input string reason);
        $display("%s", reason);
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic check_value(input string test_name, input logic [127:0] expected,
                               input logic [127:0] actual);
        if (expected !== actual) begin
            fail_run($sformatf("Mismatch in %s: expected 0x%0h, actual 0x%0h",
                               test_name, expected, actual));
        end
    endtask

    task automatic check_ar_channel();
        logic [AR_W-1:0] exp;
        if (ar_stalled_q) begin
            check_value("AR valid held under back-pressure", 1, ar_valid_o);
            check_value("AR fields held under back-pressure", ar_bus_q, ar_bus);
        end
        if (ar_valid_o && ar_ready_i) begin
            if (ar_ref_q.size() == 0) begin
                fail_run("AR channel issued a request that the far ring never held");
            end
            exp = ar_ref_q.pop_front();
            check_value("AR addr", exp[AR_ADDR_LSB +: DEF_ADDR_W], ar_addr_o);
            check_value("AR prot", exp[AR_PROT_LSB +: PROT_W], ar_prot_o);
            check_value("AR region", exp[AR_REGION_LSB +: REGION_W], ar_region_o);
            check_value("AR len", exp[AR_LEN_LSB +: LEN_W], ar_len_o);
            check_value("AR size", exp[AR_SIZE_LSB +: SIZE_W], ar_size_o);
            check_value("AR burst", exp[AR_BURST_LSB +: BURST_W], ar_burst_o);
            check_value("AR lock", exp[AR_LOCK_LSB], ar_lock_o);
            check_value("AR cache", exp[AR_CACHE_LSB +: CACHE_W], ar_cache_o);
            check_value("AR qos", exp[AR_QOS_LSB +: QOS_W], ar_qos_o);
            check_value("AR id", exp[AR_ID_LSB +: DEF_ID_W], ar_id_o);
            check_value("AR user", exp[AR_USER_LSB +: DEF_USER_W], ar_user_o);
            ar_issued++;
        end
        ar_stalled_q <= ar_valid_o && !ar_ready_i;
        ar_bus_q     <= ar_bus;
    endtask

    // Far writer stops one slot short of the DUT read pointer
    task automatic write_ar_ring();
        if (ar_pending.size() > 0 && ($random(seed) & 3) != 0
                && next_slot(ar_writetoken_i) != ar_readpointer_o) begin
            for (int i = 0; i < BUFFER_WIDTH; i++) begin
                if (ar_writetoken_i[i]) begin
                    ar_slots[i] <= ar_pending[0];
                end
            end
            ar_ref_q.push_back(ar_pending.pop_front());
            ar_writetoken_i <= next_slot(ar_writetoken_i);
        end
    endtask

    task automatic drive_r_channel();
        logic [R_W-1:0] beat;
        if (r_valid_i && r_ready_o) begin
            r_ref_q.push_back(r_beat_cur);
            r_accepted++;
        end
        // A beat not yet taken stays on the bus
        if (!r_valid_i || r_ready_o) begin
            if (r_pending.size() > 0 && ($random(seed) & 3) != 0) begin
                beat = r_pending.pop_front();
                r_beat_cur <= beat;
                r_valid_i  <= 1'b1;
                r_last_i   <= beat[R_LAST_LSB];
                r_resp_i   <= beat[R_RESP_LSB +: RESP_W];
                r_data_i   <= beat[R_DATA_LSB +: DEF_DATA_W];
                r_id_i     <= beat[R_ID_LSB +: DEF_ID_W];
                r_user_i   <= beat[R_USER_LSB +: DEF_USER_W];
            end else begin
                r_valid_i <= 1'b0;
            end
        end
    endtask

    task automatic read_r_ring();
        logic [R_W-1:0] exp;
        if (r_accepted - r_read > BUFFER_WIDTH - 1) begin
            fail_run("R ring holds more unread beats than BUFFER_WIDTH-1");
        end
        if (cycle_count >= 150 && cycle_count < 210) begin
            // Long stall, ring should fill
            if (!r_ready_o) begin
                saw_r_full = 1'b1;
            end
        end else if (r_writetoken_o != r_readpointer_i && ($random(seed) & 3) != 0) begin
            if (r_ref_q.size() == 0) begin
                fail_run("Far R reader found a beat that was never accepted");
            end
            exp = r_ref_q.pop_front();
            check_value("R data", exp[R_DATA_LSB +: DEF_DATA_W],
                        r_data_async_o[R_DATA_LSB +: DEF_DATA_W]);
            check_value("R resp", exp[R_RESP_LSB +: RESP_W], r_data_async_o[R_RESP_LSB +: RESP_W]);
            check_value("R last", exp[R_LAST_LSB], r_data_async_o[R_LAST_LSB]);
            check_value("R id", exp[R_ID_LSB +: DEF_ID_W], r_data_async_o[R_ID_LSB +: DEF_ID_W]);
            check_value("R user", exp[R_USER_LSB +: DEF_USER_W],
                        r_data_async_o[R_USER_LSB +: DEF_USER_W]);
            r_readpointer_i <= next_slot(r_readpointer_i);
            r_read++;
        end
    endtask

    always @(posedge clk) begin
        if (rst_n) begin
            check_ar_channel();
            write_ar_ring();
            // Back-pressure window fills the request buffer and the far ring
            if (cycle_count >= 300 && cycle_count < 340) begin
                ar_ready_i <= 1'b0;
            end else begin
                ar_ready_i <= (($random(seed) & 3) != 0);
            end
            drive_r_channel();
            read_r_ring();
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= MAX_CYCLES) begin
            fail_run("Run timed out before all AR requests and R beats completed");
        end
    end

    initial begin
        seed            = 63;
        cycle_count     = 0;
        ar_issued       = 0;
        r_accepted      = 0;
        r_read          = 0;
        saw_r_full      = 1'b0;
        ar_stalled_q    = 1'b0;
        ar_bus_q        = '0;
        r_beat_cur      = '0;
        ar_writetoken_i = BUFFER_WIDTH'(1);
        r_readpointer_i = BUFFER_WIDTH'(1);
        ar_ready_i      = 1'b0;
        r_valid_i       = 1'b0;
        r_data_i        = '0;
        r_resp_i        = '0;
        r_last_i        = 1'b0;
        r_id_i          = '0;
        r_user_i        = '0;
        for (int i = 0; i < BUFFER_WIDTH; i++) begin
            ar_slots[i] = '0;
        end
        for (int n = 0; n < NUM_AR; n++) begin
            ar_pending.push_back(random_ar_word());
        end
        for (int n = 0; n < NUM_R; n++) begin
            r_pending.push_back(random_r_word());
        end
        wait (rst_n == 1'b1);
        @(negedge clk);
        check_value("reset ar_valid_o", 0, ar_valid_o);
        check_value("reset ar_readpointer_o", 1, ar_readpointer_o);
        check_value("reset r_writetoken_o", 1, r_writetoken_o);
        check_value("reset r_ready_o", 1, r_ready_o);
        wait (ar_issued == NUM_AR && r_read == NUM_R);
        // Short drain so a duplicated request would still show up
        repeat (20) @(posedge clk);
        check_value("AR valid after drain", 0, ar_valid_o);
        check_value("AR read pointer after drain", ar_writetoken_i, ar_readpointer_o);
        check_value("R write token after drain", r_readpointer_i, r_writetoken_o);
        check_value("r_ready_o fell during long stall", 1, saw_r_full);
        $display("Simulation passed");
        $finish;
    end

endmodule

/* bench/tb_clk_gen.sv */
// Free-running 4 ns clock; reset held low for the first five rising edges
`timescale 1ns/1ns

module tb_clk_gen (
    output logic clk_o,
    output logic rst_n_o
);

    initial begin
        clk_o = 1'b0;
        forever #2 clk_o = ~clk_o;
    end

    initial begin
        rst_n_o = 1'b0;
        repeat (5) @(posedge clk_o);
        rst_n_o <= 1'b1;
    end

endmodule

/* design/axi_dc_pkg.sv */
// Field widths and ring word layout shared by the read path of the slice
// AR word keeps the 30-bit control layout of the full slice; bit 8 is a spare
package axi_dc_pkg;

    // AXI field widths
    localparam int PROT_W    = 3;
    localparam int REGION_W  = 4;
    localparam int LEN_W     = 8;
    localparam int SIZE_W    = 3;
    localparam int BURST_W   = 2;
    localparam int CACHE_W   = 4;
    localparam int QOS_W     = 4;
    localparam int RESP_W    = 2;

    // Control fields below the address in the AR ring word
    localparam int AR_CTRL_W = 30;

    localparam int AR_CACHE_LSB  = 0;
    localparam int AR_PROT_LSB   = 4;
    localparam int AR_LOCK_LSB   = 7;
    localparam int AR_BURST_LSB  = 9;
    localparam int AR_SIZE_LSB   = 11;
    localparam int AR_LEN_LSB    = 14;
    localparam int AR_REGION_LSB = 22;
    localparam int AR_QOS_LSB    = 26;

    // R ring word, id and user sit above the data
    localparam int R_LAST_LSB = 0;
    localparam int R_RESP_LSB = 1;
    localparam int R_DATA_LSB = 3;

    // Defaults for the top level
    localparam int DEF_ADDR_W       = 32;
    localparam int DEF_DATA_W       = 64;
    localparam int DEF_ID_W         = 6;
    localparam int DEF_USER_W       = 6;
    localparam int DEF_BUFFER_WIDTH = 8;
    localparam int DEF_BUF_DEPTH    = 2;

endpackage

/* design/axi_dc_read_master.sv */
// Read path only; AR arrives from a far ring, R leaves through a local ring
// Far side must follow the ring rules of the reader and writer blocks
`timescale 1ns/1ns

module axi_dc_read_master
    import axi_dc_pkg::*;
#(
    parameter int ADDR_W       = DEF_ADDR_W,
    parameter int DATA_W       = DEF_DATA_W,
    parameter int ID_W         = DEF_ID_W,
    parameter int USER_W       = DEF_USER_W,
    parameter int BUFFER_WIDTH = DEF_BUFFER_WIDTH,
    parameter int BUF_DEPTH    = DEF_BUF_DEPTH,
    // Ring word widths, not meant to be overridden
    parameter int AR_W         = AR_CTRL_W + ADDR_W + ID_W + USER_W,
    parameter int R_W          = R_DATA_LSB + DATA_W + ID_W + USER_W
) (
    input  logic                    clk_i,
    input  logic                    rst_n_i,
    // Far AR ring
    input  logic [BUFFER_WIDTH-1:0] ar_writetoken_i,
    input  logic [AR_W-1:0]         ar_data_async_i,
    output logic [BUFFER_WIDTH-1:0] ar_readpointer_o,
    // AXI master AR
    output logic                    ar_valid_o,
    output logic [ADDR_W-1:0]       ar_addr_o,
    output logic [PROT_W-1:0]       ar_prot_o,
    output logic [REGION_W-1:0]     ar_region_o,
    output logic [LEN_W-1:0]        ar_len_o,
    output logic [SIZE_W-1:0]       ar_size_o,
    output logic [BURST_W-1:0]      ar_burst_o,
    output logic                    ar_lock_o,
    output logic [CACHE_W-1:0]      ar_cache_o,
    output logic [QOS_W-1:0]        ar_qos_o,
    output logic [ID_W-1:0]         ar_id_o,
    output logic [USER_W-1:0]       ar_user_o,
    input  logic                    ar_ready_i,
    // AXI master R
    input  logic                    r_valid_i,
    input  logic [DATA_W-1:0]       r_data_i,
    input  logic [RESP_W-1:0]       r_resp_i,
    input  logic                    r_last_i,
    input  logic [ID_W-1:0]         r_id_i,
    input  logic [USER_W-1:0]       r_user_i,
    output logic                    r_ready_o,
    // Far R ring
    input  logic [BUFFER_WIDTH-1:0] r_readpointer_i,
    output logic [BUFFER_WIDTH-1:0] r_writetoken_o,
    output logic [R_W-1:0]          r_data_async_o
);

    localparam int AR_ADDR_LSB = AR_CTRL_W;
    localparam int AR_ID_LSB   = AR_ADDR_LSB + ADDR_W;
    localparam int AR_USER_LSB = AR_ID_LSB + ID_W;
    localparam int R_ID_LSB    = R_DATA_LSB + DATA_W;
    localparam int R_USER_LSB  = R_ID_LSB + ID_W;

    logic [AR_W-1:0] ar_ring_word;
    logic [AR_W-1:0] ar_word;
    logic            ar_ring_valid;
    logic            ar_ring_ready;
    logic [R_W-1:0]  r_word;

    dc_token_ring_reader #(
        .WIDTH        ( AR_W         ),
        .BUFFER_WIDTH ( BUFFER_WIDTH )
    ) ar_ring_reader (
        .clk_i          ( clk_i            ),
        .rst_n_i        ( rst_n_i          ),
        .write_token_i  ( ar_writetoken_i  ),
        .data_async_i   ( ar_data_async_i  ),
        .ready_i        ( ar_ring_ready    ),
        .read_pointer_o ( ar_readpointer_o ),
        .data_o         ( ar_ring_word     ),
        .valid_o        ( ar_ring_valid    )
    );

    req_buffer_fifo #(
        .WIDTH ( AR_W      ),
        .DEPTH ( BUF_DEPTH )
    ) ar_buffer (
        .clk_i   ( clk_i         ),
        .rst_n_i ( rst_n_i       ),
        .data_i  ( ar_ring_word  ),
        .valid_i ( ar_ring_valid ),
        .ready_i ( ar_ready_i    ),
        .ready_o ( ar_ring_ready ),
        .data_o  ( ar_word       ),
        .valid_o ( ar_valid_o    )
    );

    assign ar_cache_o  = ar_word[AR_CACHE_LSB  +: CACHE_W];
    assign ar_prot_o   = ar_word[AR_PROT_LSB   +: PROT_W];
    assign ar_lock_o   = ar_word[AR_LOCK_LSB];
    assign ar_burst_o  = ar_word[AR_BURST_LSB  +: BURST_W];
    assign ar_size_o   = ar_word[AR_SIZE_LSB   +: SIZE_W];
    assign ar_len_o    = ar_word[AR_LEN_LSB    +: LEN_W];
    assign ar_region_o = ar_word[AR_REGION_LSB +: REGION_W];
    assign ar_qos_o    = ar_word[AR_QOS_LSB    +: QOS_W];
    assign ar_addr_o   = ar_word[AR_ADDR_LSB   +: ADDR_W];
    assign ar_id_o     = ar_word[AR_ID_LSB     +: ID_W];
    assign ar_user_o   = ar_word[AR_USER_LSB   +: USER_W];

    assign r_word[R_LAST_LSB]            = r_last_i;
    assign r_word[R_RESP_LSB +: RESP_W]  = r_resp_i;
    assign r_word[R_DATA_LSB +: DATA_W]  = r_data_i;
    assign r_word[R_ID_LSB   +: ID_W]    = r_id_i;
    assign r_word[R_USER_LSB +: USER_W]  = r_user_i;

    dc_token_ring_writer #(
        .WIDTH        ( R_W          ),
        .BUFFER_WIDTH ( BUFFER_WIDTH )
    ) r_ring_writer (
        .clk_i          ( clk_i           ),
        .rst_n_i        ( rst_n_i         ),
        .data_i         ( r_word          ),
        .valid_i        ( r_valid_i       ),
        .read_pointer_i ( r_readpointer_i ),
        .ready_o        ( r_ready_o       ),
        .write_token_o  ( r_writetoken_o  ),
        .data_async_o   ( r_data_async_o  )
    );

endmodule

/* design/dc_token_ring_reader.sv */
// Far side writes a slot, then advances its one-hot token by one position
// Token crosses through two plain flops; the slot word must stay put until popped
`timescale 1ns/1ns

module dc_token_ring_reader
    import axi_dc_pkg::*;
#(
    parameter int WIDTH        = DEF_DATA_W,
    parameter int BUFFER_WIDTH = DEF_BUFFER_WIDTH
) (
    input  logic                    clk_i,
    input  logic                    rst_n_i,
    input  logic [BUFFER_WIDTH-1:0] write_token_i,
    input  logic [WIDTH-1:0]        data_async_i,
    input  logic                    ready_i,
    output logic [BUFFER_WIDTH-1:0] read_pointer_o,
    output logic [WIDTH-1:0]        data_o,
    output logic                    valid_o
);

    localparam logic [BUFFER_WIDTH-1:0] SLOT0 = BUFFER_WIDTH'(1);

    logic [BUFFER_WIDTH-1:0] token_meta_q;
    logic [BUFFER_WIDTH-1:0] token_sync_q;
    logic [BUFFER_WIDTH-1:0] read_pointer_q;
    logic                    pop;

    // Two-stage synchronizer on the far write token
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            token_meta_q <= SLOT0;
            token_sync_q <= SLOT0;
        end else begin
            token_meta_q <= write_token_i;
            token_sync_q <= token_meta_q;
        end
    end

    // Unread slots exist while the token is ahead of us
    assign valid_o = (token_sync_q != read_pointer_q);
    assign pop     = valid_o && ready_i;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            read_pointer_q <= SLOT0;
        end else if (pop) begin
            read_pointer_q <= {read_pointer_q[BUFFER_WIDTH-2:0],
                               read_pointer_q[BUFFER_WIDTH-1]};
        end
    end

    assign read_pointer_o = read_pointer_q;

    // Far side muxes the slot under our pointer
    assign data_o = data_async_i;

    a_pointer_onehot: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        $onehot(read_pointer_o)
    );

    // Valid only rises when the synchronized token moves
    a_valid_from_token: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        $rose(valid_o) |-> (token_sync_q != $past(token_sync_q))
    );

endmodule

/* design/dc_token_ring_writer.sv */
// Holds at most BUFFER_WIDTH-1 unread words; full test uses the synchronized pointer
// Far read pointer must be one-hot and rotate towards the higher slot
`timescale 1ns/1ns

module dc_token_ring_writer
    import axi_dc_pkg::*;
#(
    parameter int WIDTH        = DEF_DATA_W,
    parameter int BUFFER_WIDTH = DEF_BUFFER_WIDTH
) (
    input  logic                    clk_i,
    input  logic                    rst_n_i,
    input  logic [WIDTH-1:0]        data_i,
    input  logic                    valid_i,
    input  logic [BUFFER_WIDTH-1:0] read_pointer_i,
    output logic                    ready_o,
    output logic [BUFFER_WIDTH-1:0] write_token_o,
    output logic [WIDTH-1:0]        data_async_o
);

    localparam logic [BUFFER_WIDTH-1:0] SLOT0 = BUFFER_WIDTH'(1);

    logic [WIDTH-1:0]        slots_q [BUFFER_WIDTH];
    logic [BUFFER_WIDTH-1:0] write_token_q;
    logic [BUFFER_WIDTH-1:0] next_token;
    logic [BUFFER_WIDTH-1:0] ptr_meta_q;
    logic [BUFFER_WIDTH-1:0] ptr_sync_q;
    logic                    push;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            ptr_meta_q <= SLOT0;
            ptr_sync_q <= SLOT0;
        end else begin
            ptr_meta_q <= read_pointer_i;
            ptr_sync_q <= ptr_meta_q;
        end
    end

    assign next_token = {write_token_q[BUFFER_WIDTH-2:0], write_token_q[BUFFER_WIDTH-1]};

    // One slot stays empty so full and empty differ
    assign ready_o = (next_token != ptr_sync_q);
    assign push    = valid_i && ready_o;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            write_token_q <= SLOT0;
        end else if (push) begin
            write_token_q <= next_token;
        end
    end

    // Slot marked by the token takes the beat
    always_ff @(posedge clk_i) begin
        for (int i = 0; i < BUFFER_WIDTH; i++) begin
            if (push && write_token_q[i]) begin
                slots_q[i] <= data_i;
            end
        end
    end

    // AND-OR mux on the far one-hot pointer
    always_comb begin
        data_async_o = '0;
        for (int i = 0; i < BUFFER_WIDTH; i++) begin
            if (read_pointer_i[i]) begin
                data_async_o = data_async_o | slots_q[i];
            end
        end
    end

    assign write_token_o = write_token_q;

    // A taken beat never moves the token onto the far read pointer
    a_no_push_when_full: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        push |-> (next_token != read_pointer_i)
    );

    a_far_pointer_onehot: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        $onehot(read_pointer_i)
    );

endmodule

/* design/req_buffer_fifo.sv */
// Circular buffer, push and pop allowed in the same cycle
// No bypass; a push shows on valid_o one cycle later
`timescale 1ns/1ns

module req_buffer_fifo
    import axi_dc_pkg::*;
#(
    parameter int WIDTH = DEF_DATA_W,
    parameter int DEPTH = DEF_BUF_DEPTH
) (
    input  logic             clk_i,
    input  logic             rst_n_i,
    input  logic [WIDTH-1:0] data_i,
    input  logic             valid_i,
    input  logic             ready_i,
    output logic             ready_o,
    output logic [WIDTH-1:0] data_o,
    output logic             valid_o
);

    localparam int IDX_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);

    logic [WIDTH-1:0] mem_q [DEPTH];
    logic [IDX_W-1:0] rd_idx_q;
    logic [IDX_W-1:0] wr_idx_q;
    logic [CNT_W-1:0] count_q;
    logic             push;
    logic             pop;

    assign ready_o = (count_q != CNT_W'(DEPTH));
    assign valid_o = (count_q != '0);
    assign push    = valid_i && ready_o;
    assign pop     = valid_o && ready_i;
    assign data_o  = mem_q[rd_idx_q];

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            rd_idx_q <= '0;
            wr_idx_q <= '0;
            count_q  <= '0;
        end else begin
            if (push) begin
                wr_idx_q <= (wr_idx_q == IDX_W'(DEPTH - 1)) ? '0 : wr_idx_q + 1'b1;
            end
            if (pop) begin
                rd_idx_q <= (rd_idx_q == IDX_W'(DEPTH - 1)) ? '0 : rd_idx_q + 1'b1;
            end
            if (push && !pop) begin
                count_q <= count_q + 1'b1;
            end else if (pop && !push) begin
                count_q <= count_q - 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (push) begin
            mem_q[wr_idx_q] <= data_i;
        end
    end

    // Indices meet only when empty or full, so writes never lap the read index
    a_no_overflow: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        (wr_idx_q == rd_idx_q) == (count_q == '0 || count_q == CNT_W'(DEPTH))
    );

    // AXI hold rule under back-pressure
    a_hold_while_stalled: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        (valid_o && !ready_i) |=> (valid_o && $stable(data_o))
    );

endmodule

/* tb.f */
design/axi_dc_pkg.sv
design/dc_token_ring_reader.sv
design/dc_token_ring_writer.sv
design/req_buffer_fifo.sv
design/axi_dc_read_master.sv
bench/tb_clk_gen.sv
bench/tb_axi_dc_read_master.sv
